// ==== verilog/ising_pkg.sv ====
// Shared sizes and bus types for the coupled-oscillator Ising machine
// Holds the array geometry, the weight encoding and the write request layout
`default_nettype none

package ising_pkg;

    // Number of spins
    // The cell array is NUM_SPINS by NUM_SPINS
    localparam int NUM_SPINS = 4;

    // Delay taps per cell
    // Must be odd so that a neutral middle tap exists
    localparam int NUM_WEIGHTS = 15;

    // Bits needed to hold a tap index
    localparam int WEIGHT_W = $clog2(NUM_WEIGHTS);

    // Middle tap gives the same delay for match and mismatch
    localparam logic [WEIGHT_W-1:0] WEIGHT_RESET = WEIGHT_W'(NUM_WEIGHTS / 2);

    // Register stages that model one LUT buffer
    localparam int NUM_LUTS = 2;

    // Cell address is row * NUM_SPINS + column
    localparam int ADDR_W = 4;

    // Write request, valid in the cycle where wready is high
    typedef struct packed {
        logic              wready;
        logic [ADDR_W-1:0] waddr;
        logic [31:0]       wdata;
    } bus_wr_t;

    // One phase or sign bit per spin
    typedef logic [NUM_SPINS-1:0] spin_vec_t;

endpackage

`default_nettype wire

// ==== verilog/delay_buffer.sv ====
// Clocked stand-in for one LUT delay element
// Shifts the phase edge through NUM_LUTS register stages
`timescale 1ns/1ps
`default_nettype none

module delay_buffer (
    input  logic clk,
    input  logic ising_rstn,
    input  logic in,
    output logic out
);
    import ising_pkg::*;

    // One register per LUT in the original chain
    logic [NUM_LUTS-1:0] stage;

    always_ff @(posedge clk) begin
        if (!ising_rstn) begin
            stage <= '0;
        end else begin
            stage[0] <= in;
            for (int k = 1; k < NUM_LUTS; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    // Oldest stage is the delayed phase
    assign out = stage[NUM_LUTS-1];

endmodule

`default_nettype wire

// ==== verilog/coupled_cell.sv ====
// One coupling cell of the oscillator ring
// Delays the phase edge by a tap picked from the stored weight
// and from whether the edge agrees with the source spin
`timescale 1ns/1ps
`default_nettype none

module coupled_cell (
    input  logic        ising_rstn,
    input  logic        sout,
    input  logic        din,
    output logic        dout,
    input  logic        clk,
    input  logic        axi_rstn,
    input  logic        wready,
    input  logic        wr_addr_match,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    import ising_pkg::*;

    logic [WEIGHT_W-1:0]    weight;
    logic [NUM_WEIGHTS-1:0] weight_oh;
    logic [NUM_WEIGHTS-1:0] d_buf;
    logic [NUM_WEIGHTS-1:0] sel_mi;
    logic [NUM_WEIGHTS-1:0] sel_ma;
    logic                   mismatch;
    logic                   dout_pre;
    logic                   dout_int;

    // Weight register written from the bus
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            weight <= WEIGHT_RESET;
        end else if (wready && wr_addr_match) begin
            weight <= wdata[WEIGHT_W-1:0];
        end
    end

    // Readback is the weight with zero upper bits
    assign rdata = {{(32 - WEIGHT_W){1'b0}}, weight};

    // Tap chain
    // Tap t is NUM_LUTS * (t + 1) cycles behind din
    for (genvar t = 0; t < NUM_WEIGHTS; t++) begin : g_tap
        if (t == 0) begin : g_first
            delay_buffer u_buf (
                .clk        (clk),
                .ising_rstn (ising_rstn),
                .in         (din),
                .out        (d_buf[t])
            );
        end else begin : g_next
            delay_buffer u_buf (
                .clk        (clk),
                .ising_rstn (ising_rstn),
                .in         (d_buf[t-1]),
                .out        (d_buf[t])
            );
        end
    end

    // One-hot weight gates the two candidate taps
    // A mismatched edge uses tap = weight
    // A matched edge uses the mirrored tap
    for (genvar t = 0; t < NUM_WEIGHTS; t++) begin : g_sel
        assign weight_oh[t] = (weight == WEIGHT_W'(t));
        assign sel_mi[t]    = weight_oh[t] & d_buf[t];
        assign sel_ma[t]    = weight_oh[NUM_WEIGHTS-1-t] & d_buf[t];
    end

    // Edge disagrees with the source spin
    assign mismatch = sout ^ din;
    assign dout_pre = mismatch ? (|sel_mi) : (|sel_ma);

    // Output buffer adds NUM_LUTS more cycles
    delay_buffer u_out_buf (
        .clk        (clk),
        .ising_rstn (ising_rstn),
        .in         (dout_pre),
        .out        (dout_int)
    );

    // Hold the ring low while the oscillators are stopped
    assign dout = ising_rstn & dout_int;

endmodule

`default_nettype wire

// ==== verilog/weight_bus.sv ====
// Register bus front end for the weight array
// Decodes the write address per cell and muxes the cell readback
`timescale 1ns/1ps
`default_nettype none

module weight_bus (
    input  ising_pkg::bus_wr_t                                     wr,
    input  logic [ising_pkg::ADDR_W-1:0]                           raddr,
    input  logic [31:0] cell_rdata [ising_pkg::NUM_SPINS*ising_pkg::NUM_SPINS],
    output logic [ising_pkg::NUM_SPINS*ising_pkg::NUM_SPINS-1:0]   wr_addr_match,
    output logic [31:0]                                            rdata
);
    import ising_pkg::*;

    localparam int NUM_CELLS = NUM_SPINS * NUM_SPINS;

    // One match line per cell
    // wready is qualified inside the cell
    always_comb begin
        for (int c = 0; c < NUM_CELLS; c++) begin
            wr_addr_match[c] = (wr.waddr == ADDR_W'(c));
        end
    end

    // Readback mux
    // An address with no cell behind it reads 0
    always_comb begin
        rdata = '0;
        for (int c = 0; c < NUM_CELLS; c++) begin
            if (raddr == ADDR_W'(c)) begin
                rdata = cell_rdata[c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/spin_readout.sv ====
// Spin sign readout
// Samples every phase against spin 0 on the rising edge of phase[0]
`timescale 1ns/1ps
`default_nettype none

module spin_readout (
    input  logic                 clk,
    input  logic                 axi_rstn,
    input  ising_pkg::spin_vec_t phase,
    output ising_pkg::spin_vec_t spins,
    output logic                 spins_valid
);
    import ising_pkg::*;

    logic ref_q;
    logic ref_rise;

    // Reference spin one cycle back
    // Its rising edge marks a sample point
    assign ref_rise = phase[0] & ~ref_q;

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            ref_q       <= 1'b0;
            spins       <= '0;
            spins_valid <= 1'b0;
        end else begin
            ref_q       <= phase[0];
            spins_valid <= ref_rise;
            // Sign relative to spin 0
            if (ref_rise) begin
                spins <= phase ^ {NUM_SPINS{phase[0]}};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ising_core.sv ====
// Top of the coupled-oscillator Ising machine
// Rows of coupled cells form one ring oscillator per spin
// The weight bus reaches every cell and the readout samples the rings
`timescale 1ns/1ps
`default_nettype none

module ising_core (
    input  logic                         clk,
    input  logic                         axi_rstn,
    input  logic                         ising_rstn,
    input  ising_pkg::bus_wr_t           wr,
    input  logic [ising_pkg::ADDR_W-1:0] raddr,
    output logic [31:0]                  rdata,
    output ising_pkg::spin_vec_t         phase,
    output ising_pkg::spin_vec_t         spins,
    output logic                         spins_valid
);
    import ising_pkg::*;

    localparam int NUM_CELLS = NUM_SPINS * NUM_SPINS;

    logic [NUM_CELLS-1:0] wr_addr_match;
    logic [31:0]          cell_rdata [NUM_CELLS];
    logic [NUM_SPINS-1:0] cell_dout  [NUM_SPINS];
    logic [NUM_SPINS-1:0] ring_fb;

    // Row i is the ring of spin i
    // Column j couples it to spin j
    for (genvar i = 0; i < NUM_SPINS; i++) begin : g_row
        // Ring closes through one inverter
        assign ring_fb[i] = ~cell_dout[i][NUM_SPINS-1];
        assign phase[i]   = cell_dout[i][NUM_SPINS-1];

        for (genvar j = 0; j < NUM_SPINS; j++) begin : g_col
            coupled_cell u_cell (
                .ising_rstn    (ising_rstn),
                .sout          (phase[j]),
                .din           ((j == 0) ? ring_fb[i] : cell_dout[i][(j == 0) ? 0 : j-1]),
                .dout          (cell_dout[i][j]),
                .clk           (clk),
                .axi_rstn      (axi_rstn),
                .wready        (wr.wready),
                .wr_addr_match (wr_addr_match[i*NUM_SPINS+j]),
                .wdata         (wr.wdata),
                .rdata         (cell_rdata[i*NUM_SPINS+j])
            );
        end
    end

    weight_bus u_weight_bus (
        .wr            (wr),
        .raddr         (raddr),
        .cell_rdata    (cell_rdata),
        .wr_addr_match (wr_addr_match),
        .rdata         (rdata)
    );

    spin_readout u_spin_readout (
        .clk         (clk),
        .axi_rstn    (axi_rstn),
        .phase       (phase),
        .spins       (spins),
        .spins_valid (spins_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock source
// Free-running clk with a 20 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);
    // Half of the 20 ns period
    localparam realtime HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/ising_checker.sv ====
// Result checker for the Ising machine testbench
// Compares DUT outputs with expected values and keeps per-test counts
`timescale 1ns/1ps
`default_nettype none

module ising_checker (
    input  logic [31:0]          rdata,
    input  ising_pkg::spin_vec_t phase,
    input  ising_pkg::spin_vec_t spins,
    input  logic                 spins_valid,
    output int                   total_errors,
    output int                   total_checks,
    output int                   tests_passed,
    output int                   tests_failed
);
    import ising_pkg::*;

    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int test_checks = 0;
    int passed = 0;
    int failed = 0;

    assign total_errors = errors;
    assign total_checks = checks;
    assign tests_passed = passed;
    assign tests_failed = failed;

    // Generic compare, one ERROR line per mismatch
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    // Failures that are not a wrong value
    task automatic report_failure(input string msg);
        errors++;
        test_errors++;
        $display("FAILURE at %0t: %s", $time, msg);
    endtask

    // Readback of the addressed cell
    task automatic check_rdata(input logic [31:0] exp);
        check_value("rdata", exp, rdata);
    endtask

    task automatic check_phase(input spin_vec_t exp);
        check_value("phase", 32'(exp), 32'(phase));
    endtask

    task automatic check_spins(input spin_vec_t exp);
        check_value("spins", 32'(exp), 32'(spins));
    endtask

    task automatic check_valid(input logic exp);
        check_value("spins_valid", 32'(exp), 32'(spins_valid));
    endtask

    // One summary line per finished test
    task automatic end_test(input int id);
        if (test_errors == 0) begin
            passed++;
            $display("test %0d ok, %0d checks", id, test_checks);
        end else begin
            failed++;
            $display("test %0d failed, %0d of %0d checks wrong", id, test_errors, test_checks);
        end
        test_errors = 0;
        test_checks = 0;
    endtask

endmodule

`default_nettype wire

// ==== testbench/ising_assert.sv ====
// Protocol and reset assertions for ising_core
// Bound into the core from the testbench top
`timescale 1ns/1ps
`default_nettype none

module ising_assert (
    input logic                         clk,
    input logic                         axi_rstn,
    input logic                         ising_rstn,
    input ising_pkg::bus_wr_t           wr,
    input logic [ising_pkg::ADDR_W-1:0] raddr,
    input logic [31:0]                  rdata,
    input ising_pkg::spin_vec_t         phase,
    input logic                         spins_valid
);
    import ising_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    // Stopped rings stay low and restart from cleared stages
    a_phase_idle: assert property (@(posedge clk) !ising_rstn |=> phase == '0)
        else begin
            fail_count++;
            $error("phase is active after ising_rstn was low");
        end

    // Readout pulse comes one cycle after phase[0] rises
    // Two pulses in a row cannot happen then
    a_valid_pulse: assert property (@(posedge clk) disable iff (!axi_rstn)
        spins_valid |-> $past(phase[0]) && !$past(phase[0], 2))
        else begin
            fail_count++;
            $error("spins_valid without a rising edge of phase[0] one cycle earlier");
        end

    // Written weight shows up on rdata one cycle later
    a_write_visible: assert property (@(posedge clk) disable iff (!axi_rstn)
        (wr.wready && (32'(wr.waddr) < NUM_SPINS * NUM_SPINS))
        |=> (raddr != $past(wr.waddr))
            || (rdata == 32'($past(wr.wdata[WEIGHT_W-1:0]))))
        else begin
            fail_count++;
            $error("write not visible on rdata");
        end

endmodule

`default_nettype wire

// ==== testbench/ising_tb.sv ====
// Testbench top for the coupled-oscillator Ising machine
// Runs the pattern file through the weight bus and the oscillator rings
`timescale 1ns/1ps
`default_nettype none

module ising_tb;
    import ising_pkg::*;

    localparam int    NUM_CELLS    = NUM_SPINS * NUM_SPINS;
    localparam string PATTERN_FILE = "testbench/ising_patterns.txt";

    // Pattern opcodes, ASCII letters as used in the file
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,
        OP_READ  = 8'h52,
        OP_HOLD  = 8'h48,
        OP_OSC   = 8'h4f,
        OP_SPIN  = 8'h53
    } op_t;

    typedef struct packed {
        op_t         op;
        int          test_id;
        logic [31:0] addr;
        logic [31:0] data;
        int          count;
    } pattern_t;

    logic        clk;
    logic        axi_rstn;
    logic        ising_rstn;
    bus_wr_t     wr;
    logic [ADDR_W-1:0] raddr;
    logic [31:0] rdata;
    spin_vec_t   phase;
    spin_vec_t   spins;
    logic        spins_valid;
    int          total_errors;
    int          total_checks;
    int          tests_passed;
    int          tests_failed;

    pattern_t          patterns[$];
    logic [WEIGHT_W-1:0] model [NUM_CELLS];
    int                cycle_count = 0;
    int                cycle_limit = 0;

    tb_clock_gen u_clock (.clk(clk));

    ising_core ising_core_inst (
        .clk         (clk),
        .axi_rstn    (axi_rstn),
        .ising_rstn  (ising_rstn),
        .wr          (wr),
        .raddr       (raddr),
        .rdata       (rdata),
        .phase       (phase),
        .spins       (spins),
        .spins_valid (spins_valid)
    );

    ising_checker u_checker (
        .rdata        (rdata),
        .phase        (phase),
        .spins        (spins),
        .spins_valid  (spins_valid),
        .total_errors (total_errors),
        .total_checks (total_checks),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    bind ising_core ising_assert u_assert (
        .clk         (clk),
        .axi_rstn    (axi_rstn),
        .ising_rstn  (ising_rstn),
        .wr          (wr),
        .raddr       (raddr),
        .rdata       (rdata),
        .phase       (phase),
        .spins_valid (spins_valid)
    );

    // Run limit, armed once the pattern length is known
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Parse the pattern file, skipping comments and blank lines
    task automatic load_patterns(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         opc;
        int          tid;
        int          cnt;
        logic [31:0] a;
        logic [31:0] d;
        pattern_t    p;
        ok = 1'b1;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %d %h %h %d", opc, tid, a, d, cnt);
                    if (n != 5 || !(opc inside {8'h57, 8'h52, 8'h48, 8'h4f, 8'h53})) begin
                        $display("bad pattern line: %s", line);
                        ok = 1'b0;
                    end else begin
                        p.op      = op_t'(opc);
                        p.test_id = tid;
                        p.addr    = a;
                        p.data    = d;
                        p.count   = cnt;
                        patterns.push_back(p);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Cycles each opcode may take, plus slack per line
    function automatic int pattern_cycles(input pattern_t p);
        case (p.op)
            OP_READ: return 2 * p.count + 4;
            OP_HOLD: return p.count + 4;
            OP_OSC:  return p.count * (2 * int'(p.data) + 2) + 4;
            OP_SPIN: return p.count + 4;
            default: return 4;
        endcase
    endfunction

    // Flag 0 drives the address and data without wready
    task automatic write_weight(input pattern_t p);
        @(negedge clk);
        wr.wready = p.count != 0;
        wr.waddr  = p.addr[ADDR_W-1:0];
        wr.wdata  = p.data;
        raddr     = p.addr[ADDR_W-1:0];
        if (p.count != 0) begin
            // Only the low WEIGHT_W bits are stored
            model[p.addr[ADDR_W-1:0]] = p.data[WEIGHT_W-1:0];
        end
    endtask

    // Address ff picks random cells and expects the model weight
    task automatic read_weights(input pattern_t p);
        int          a;
        logic [31:0] exp;
        for (int k = 0; k < p.count; k++) begin
            if (p.addr == 32'hff) begin
                a   = int'($urandom % NUM_CELLS);
                exp = 32'(model[a]);
            end else begin
                a   = int'(p.addr) + k;
                exp = p.data;
            end
            @(negedge clk);
            wr.wready = 1'b0;
            raddr     = ADDR_W'(a);
            @(negedge clk);
            u_checker.check_rdata(exp);
        end
    endtask

    // Rings held stopped while random writes rewrite current weights
    task automatic hold_oscillators(input pattern_t p);
        int a;
        for (int k = 0; k < p.count; k++) begin
            @(negedge clk);
            u_checker.check_phase('0);
            a          = int'($urandom % NUM_CELLS);
            ising_rstn = 1'b0;
            wr.wready  = 1'($urandom % 2);
            wr.waddr   = ADDR_W'(a);
            wr.wdata   = ($urandom << WEIGHT_W) | 32'(model[a]);
        end
    endtask

    // Release the rings and time count half-periods
    task automatic watch_phase(input pattern_t p);
        spin_vec_t last;
        int        cycles;
        bit        changed;
        bit        stopped;
        @(negedge clk);
        ising_rstn = 1'b1;
        wr.wready  = 1'b0;
        last       = phase;
        stopped    = 1'b0;
        for (int h = 0; h < p.count && !stopped; h++) begin
            cycles  = 0;
            changed = 1'b0;
            while (!changed && cycles < 2 * int'(p.data) + 2) begin
                @(negedge clk);
                cycles++;
                changed = phase !== last;
            end
            if (!changed) begin
                u_checker.report_failure("phase stopped toggling");
                stopped = 1'b1;
            end else begin
                u_checker.check_value("half_period", p.data, 32'(cycles));
                // All rings move together with uniform weights
                u_checker.check_phase(~last);
                last = phase;
            end
        end
    endtask

    // Wait for a rising phase[0] and check the readout pulse after it
    task automatic sample_spins(input pattern_t p);
        logic prev;
        bit   found;
        int   k;
        if (p.count == 0) begin
            @(negedge clk);
            wr.wready = 1'b0;
            u_checker.check_spins(spin_vec_t'(p.data));
            u_checker.check_valid(1'b0);
        end else begin
            prev  = phase[0];
            found = 1'b0;
            k     = 0;
            while (!found && k < p.count) begin
                @(negedge clk);
                wr.wready = 1'b0;
                k++;
                found = phase[0] && !prev;
                prev  = phase[0];
            end
            if (!found) begin
                u_checker.report_failure("no rising edge on phase[0] in the wait window");
            end else begin
                u_checker.check_valid(1'b0);
                @(negedge clk);
                u_checker.check_valid(1'b1);
                u_checker.check_spins(spin_vec_t'(p.data));
                @(negedge clk);
                u_checker.check_valid(1'b0);
            end
        end
    endtask

    initial begin
        bit ok;
        int cur_test;
        axi_rstn   = 1'b0;
        ising_rstn = 1'b0;
        wr         = '0;
        raddr      = '0;
        void'($urandom(18614));
        load_patterns(ok);
        if (!ok) begin
            $display("pattern file %s could not be read", PATTERN_FILE);
            $display("*** FAILED ***");
            $finish;
        end else begin
            cycle_limit = 8 + 200;
            foreach (patterns[i]) begin
                cycle_limit += pattern_cycles(patterns[i]);
            end
            for (int c = 0; c < NUM_CELLS; c++) begin
                model[c] = WEIGHT_RESET;
            end
            // Bus reset for 8 cycles
            repeat (8) @(negedge clk);
            axi_rstn = 1'b1;
            cur_test = 0;
            foreach (patterns[i]) begin
                if (patterns[i].test_id != cur_test && cur_test != 0) begin
                    u_checker.end_test(cur_test);
                end
                cur_test = patterns[i].test_id;
                case (patterns[i].op)
                    OP_WRITE: write_weight(patterns[i]);
                    OP_READ:  read_weights(patterns[i]);
                    OP_HOLD:  hold_oscillators(patterns[i]);
                    OP_OSC:   watch_phase(patterns[i]);
                    default:  sample_spins(patterns[i]);
                endcase
            end
            @(negedge clk);
            wr.wready = 1'b0;
            if (cur_test != 0) begin
                u_checker.end_test(cur_test);
            end
            $display("tests passed %0d failed %0d, checks %0d, errors %0d, assertion failures %0d",
                     tests_passed, tests_failed, total_checks, total_errors,
                     ising_core_inst.u_assert.fail_count);
            if (total_errors == 0 && tests_failed == 0 && tests_passed > 0
                    && ising_core_inst.u_assert.fail_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/ising_patterns.txt ====
# columns: opcode test addr(hex) data(hex) count(dec)
# W write (count 1 = wready), R read expect (addr ff = random), H hold, O osc, S spins
R 1 0 7 16
S 1 0 0 0
W 2 3 a5 1
R 2 3 5 1
W 2 9 fffffffc 1
R 2 9 c 1
W 2 e 12 1
R 2 e 2 1
W 3 3 b 0
R 3 3 5 1
W 3 4 1 1
R 3 3 5 1
R 3 4 1 1
R 3 ff 0 6
W 3 3 7 1
W 3 9 7 1
W 3 e 7 1
W 3 4 7 1
R 3 0 7 16
H 4 0 0 300
O 5 0 48 4
S 6 0 0 160
S 6 0 0 160
S 6 0 0 160

// ==== ising_core.f ====
verilog/ising_pkg.sv
verilog/delay_buffer.sv
verilog/coupled_cell.sv
verilog/weight_bus.sv
verilog/spin_readout.sv
verilog/ising_core.sv
testbench/tb_clock_gen.sv
testbench/ising_checker.sv
testbench/ising_assert.sv
testbench/ising_tb.sv

// ==== Makefile ====
# Verilator build and run for the Ising machine testbench

VERILATOR ?= verilator
TOP       ?= ising_tb
FILELIST  ?= ising_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
